//--- src/btb_pkg.sv
//----------------------------------------------------------------------
// widths and record types shared by every block of the branch target
// buffer, referenced by scoped name
//----------------------------------------------------------------------
package btb_pkg;

	localparam int PC_W        = 32;	// pc and target width
	localparam int OFS_W       = 2;	// word offset bits, never looked at
	localparam int TAG_W       = 20;	// partial tag from pc[31:12]
	localparam int MAX_INDEX_W = 10;	// index must stay below the tag
	localparam int WAYS        = 4;	// fixed by the 3-bit tree plru
	localparam int WAY_W       = 2;	// way number width

	// one stored way entry, 53 bits
	typedef struct packed {
		logic             valid;	// entry holds a branch
		logic [TAG_W-1:0] tag;	// partial tag
		logic [PC_W-1:0]  target;	// predicted target
	} btb_entry_t;

	typedef struct packed {
		logic [PC_W-1:0] pc;	// fetch pc
	} btb_lkp_t;

	typedef struct packed {
		logic [PC_W-1:0] pc;	// resolved branch pc
		logic [PC_W-1:0] target;	// resolved target
	} btb_upd_t;

	// request in flight between the req and match stages
	typedef struct packed {
		logic            upd;	// 1 update, 0 lookup
		logic [PC_W-1:0] pc;
		logic [PC_W-1:0] target;	// zero for lookups
	} btb_slot_t;

	typedef struct packed {
		logic            hit;
		logic [PC_W-1:0] target;	// zero on a miss
		logic [PC_W-1:0] pc;	// echo of the looked-up pc
	} btb_rsp_t;

	typedef struct packed {
		logic             en;	// commit this cycle
		logic [WAY_W-1:0] way;	// way being written
		btb_entry_t       entry;
	} btb_wr_t;

endpackage

//--- src/btb_req_stage.sv
//----------------------------------------------------------------------
// request stage: picks update over lookup, holds the slot in flight
// and addresses the way arrays with the index being accepted
//----------------------------------------------------------------------
module btb_req_stage #(
	parameter int INDEX_W = 6
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               lkp_valid,
	output logic               lkp_ready,
	input  btb_pkg::btb_lkp_t  lkp,
	input  logic               upd_valid,
	output logic               upd_ready,
	input  btb_pkg::btb_upd_t  upd,
	input  logic               slot_take,	// slot leaves this cycle
	output logic               slot_valid,
	output btb_pkg::btb_slot_t slot,
	output logic [INDEX_W-1:0] rd_index
);

	logic               can_accept;	// slot empty or emptying
	logic               upd_fire;
	logic               lkp_fire;
	btb_pkg::btb_slot_t slot_d;	// next slot contents

	assign can_accept = !slot_valid || slot_take;
	assign upd_ready  = can_accept;
	assign lkp_ready  = can_accept && !upd_valid;	// updates win
	assign upd_fire   = upd_valid && upd_ready;
	assign lkp_fire   = lkp_valid && lkp_ready;

	always_comb begin
		slot_d = slot;	// hold by default
		if (upd_fire) begin
			slot_d.upd    = 1'b1;
			slot_d.pc     = upd.pc;
			slot_d.target = upd.target;
		end else if (lkp_fire) begin
			slot_d.upd    = 1'b0;
			slot_d.pc     = lkp.pc;
			slot_d.target = '0;	// unused on lookups
		end
	end

	// accepted index, or the held slot's own index when idle
	assign rd_index = slot_d.pc[btb_pkg::OFS_W +: INDEX_W];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_valid <= 1'b0;
		end else if (can_accept) begin
			slot_valid <= upd_fire || lkp_fire;
		end
	end

	always_ff @(posedge clk) begin
		slot <= slot_d;	// payload only
	end

	// a stalled slot keeps its request until the match stage takes it
	a_slot_hold: assert property (@(posedge clk) disable iff (!arst_n)
		slot_valid && !slot_take |=> slot_valid && $stable(slot));

endmodule

//--- src/btb_way_ram.sv
//----------------------------------------------------------------------
// one way of the buffer, registered write-first read aligned with the
// slot, one instance per way
//----------------------------------------------------------------------
module btb_way_ram #(
	parameter int INDEX_W = 6
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [INDEX_W-1:0]          rd_index,
	input  btb_pkg::btb_wr_t            wr,
	input  logic [btb_pkg::WAY_W-1:0]   way_id,	// this instance's way
	input  logic [INDEX_W-1:0]          wr_index,
	output btb_pkg::btb_entry_t         rd_entry
);

	localparam int SETS = 2 ** INDEX_W;

	logic [btb_pkg::TAG_W-1:0] tag_mem [SETS];
	logic [btb_pkg::PC_W-1:0]  tgt_mem [SETS];
	logic [SETS-1:0]           valid_q;	// per set valid bit
	logic                      we;

	assign we = wr.en && (wr.way == way_id);	// way decode

	always_ff @(posedge clk) begin
		if (we) begin
			tag_mem[wr_index] <= wr.entry.tag;
			tgt_mem[wr_index] <= wr.entry.target;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;	// empty buffer
		end else if (we) begin
			valid_q[wr_index] <= wr.entry.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (we && (wr_index == rd_index)) begin
			rd_entry <= wr.entry;	// forward same-edge write
		end else begin
			rd_entry.valid  <= valid_q[rd_index];
			rd_entry.tag    <= tag_mem[rd_index];
			rd_entry.target <= tgt_mem[rd_index];
		end
	end

endmodule

//--- src/btb_plru.sv
//----------------------------------------------------------------------
// per-set 3-bit tree pseudo-lru, gives the victim for the slot's set
// and moves only on update commits
//----------------------------------------------------------------------
module btb_plru #(
	parameter int INDEX_W = 6
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic [INDEX_W-1:0]        index,	// slot's set
	input  btb_pkg::btb_wr_t          wr,
	output logic [btb_pkg::WAY_W-1:0] victim
);

	localparam int SETS = 2 ** INDEX_W;

	logic [2:0] plru_q [SETS];	// bit0 pair, bit1 pair 0, bit2 pair 1
	logic [2:0] cur;
	logic [2:0] nxt;

	assign cur = plru_q[index];

	// walk the tree toward the older side
	always_comb begin
		if (cur[0]) begin
			victim = cur[2] ? 2'd3 : 2'd2;	// pair 1
		end else begin
			victim = cur[1] ? 2'd1 : 2'd0;	// pair 0
		end
	end

	//------------------------------------------------------------------
	// point the tree away from the way just written
	//------------------------------------------------------------------
	always_comb begin
		nxt = cur;
		case (wr.way)
			2'd0: begin
				nxt[1] = 1'b1;	// way 1 next in pair 0
				nxt[0] = 1'b1;	// then pair 1
			end
			2'd1: begin
				nxt[1] = 1'b0;
				nxt[0] = 1'b1;
			end
			2'd2: begin
				nxt[2] = 1'b1;	// way 3 next in pair 1
				nxt[0] = 1'b0;	// then pair 0
			end
			default: begin
				nxt[2] = 1'b0;
				nxt[0] = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int s = 0; s < SETS; s++) begin
				plru_q[s] <= 3'b000;	// fill order 0 2 1 3
			end
		end else if (wr.en) begin
			plru_q[index] <= nxt;
		end
	end

	// index comes from the slot, so a committing update needs a clean victim
	a_victim_known: assert property (@(posedge clk) disable iff (!arst_n)
		wr.en |-> !$isunknown(victim));

endmodule

//--- src/btb_tag_match.sv
//----------------------------------------------------------------------
// match stage: tag compare over the four ways, lookup responses with
// back-pressure, and the commit of updates
//----------------------------------------------------------------------
module btb_tag_match #(
	parameter int INDEX_W = 6
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      slot_valid,
	input  btb_pkg::btb_slot_t        slot,
	input  btb_pkg::btb_entry_t       rd_entry0,
	input  btb_pkg::btb_entry_t       rd_entry1,
	input  btb_pkg::btb_entry_t       rd_entry2,
	input  btb_pkg::btb_entry_t       rd_entry3,
	input  logic [btb_pkg::WAY_W-1:0] victim,
	output logic                      slot_take,
	output btb_pkg::btb_wr_t          wr,
	output logic [INDEX_W-1:0]        wr_index,
	output logic                      rsp_valid,
	input  logic                      rsp_ready,
	output btb_pkg::btb_rsp_t         rsp
);

	btb_pkg::btb_entry_t       entry [btb_pkg::WAYS];
	logic [btb_pkg::WAYS-1:0]  hit_vec;
	logic                      hit;
	logic [btb_pkg::WAY_W-1:0] hit_way;
	logic [btb_pkg::PC_W-1:0]  hit_target;	// zero on a miss
	logic [btb_pkg::TAG_W-1:0] slot_tag;
	logic                      rsp_free;	// response reg can load
	logic                      rsp_load;

	assign entry[0] = rd_entry0;
	assign entry[1] = rd_entry1;
	assign entry[2] = rd_entry2;
	assign entry[3] = rd_entry3;

	assign slot_tag = slot.pc[btb_pkg::PC_W-1 -: btb_pkg::TAG_W];
	assign wr_index = slot.pc[btb_pkg::OFS_W +: INDEX_W];

	always_comb begin
		hit_vec    = '0;
		hit_way    = '0;
		hit_target = '0;
		for (int w = 0; w < btb_pkg::WAYS; w++) begin
			hit_vec[w] = entry[w].valid && (entry[w].tag == slot_tag);
			if (hit_vec[w]) begin
				hit_way    = btb_pkg::WAY_W'(w);
				hit_target = entry[w].target;
			end
		end
	end
	assign hit = |hit_vec;

	//------------------------------------------------------------------
	// update commit, same tag rewrites its way, new tag takes the victim
	//------------------------------------------------------------------
	always_comb begin
		wr.en           = slot_valid && slot.upd;
		wr.way          = hit ? hit_way : victim;
		wr.entry.valid  = 1'b1;
		wr.entry.tag    = slot_tag;
		wr.entry.target = slot.target;
	end

	assign rsp_free  = !rsp_valid || rsp_ready;
	assign rsp_load  = slot_valid && !slot.upd && rsp_free;
	assign slot_take = slot_valid && (slot.upd || rsp_free);	// updates never wait

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid <= 1'b0;
		end else if (rsp_free) begin
			rsp_valid <= rsp_load;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_load) begin
			rsp.hit    <= hit;
			rsp.target <= hit_target;
			rsp.pc     <= slot.pc;
		end
	end

	// commit path must never leave a tag twice in one set
	a_hit_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		slot_valid |-> $onehot0(hit_vec));

	a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

//--- src/btb_top.sv
//----------------------------------------------------------------------
// four-way branch target buffer with lookup, update and response
// streams, set count chosen by INDEX_W
//----------------------------------------------------------------------
module btb_top #(
	parameter int INDEX_W = 6	// sets = 2**INDEX_W
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              lkp_valid,
	output logic              lkp_ready,
	input  btb_pkg::btb_lkp_t lkp,
	input  logic              upd_valid,
	output logic              upd_ready,
	input  btb_pkg::btb_upd_t upd,
	output logic              rsp_valid,
	input  logic              rsp_ready,
	output btb_pkg::btb_rsp_t rsp
);

	logic                      slot_valid;
	logic                      slot_take;
	btb_pkg::btb_slot_t        slot;
	logic [INDEX_W-1:0]        rd_index;	// to all four ways
	btb_pkg::btb_entry_t       rd_entry [btb_pkg::WAYS];
	logic [btb_pkg::WAY_W-1:0] victim;
	btb_pkg::btb_wr_t          wr;
	logic [INDEX_W-1:0]        wr_index;	// slot's set

	//------------------------------------------------------------------
	// producer
	//------------------------------------------------------------------
	btb_req_stage #(
		.INDEX_W (INDEX_W)
	) req_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.lkp_valid  (lkp_valid),
		.lkp_ready  (lkp_ready),
		.lkp        (lkp),
		.upd_valid  (upd_valid),
		.upd_ready  (upd_ready),
		.upd        (upd),
		.slot_take  (slot_take),
		.slot_valid (slot_valid),
		.slot       (slot),
		.rd_index   (rd_index)
	);

	//------------------------------------------------------------------
	// buffer
	//------------------------------------------------------------------
	for (genvar w = 0; w < btb_pkg::WAYS; w++) begin : g_way
		btb_way_ram #(
			.INDEX_W (INDEX_W)
		) way_i (
			.clk      (clk),
			.arst_n   (arst_n),
			.rd_index (rd_index),
			.wr       (wr),
			.way_id   (btb_pkg::WAY_W'(w)),	// way number of this array
			.wr_index (wr_index),
			.rd_entry (rd_entry[w])
		);
	end

	btb_plru #(
		.INDEX_W (INDEX_W)
	) plru_i (
		.clk    (clk),
		.arst_n (arst_n),
		.index  (wr_index),	// victim and commit share the slot's set
		.wr     (wr),
		.victim (victim)
	);

	//------------------------------------------------------------------
	// consumer
	//------------------------------------------------------------------
	btb_tag_match #(
		.INDEX_W (INDEX_W)
	) match_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.slot_valid (slot_valid),
		.slot       (slot),
		.rd_entry0  (rd_entry[0]),
		.rd_entry1  (rd_entry[1]),
		.rd_entry2  (rd_entry[2]),
		.rd_entry3  (rd_entry[3]),
		.victim     (victim),
		.slot_take  (slot_take),
		.wr         (wr),
		.wr_index   (wr_index),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready),
		.rsp        (rsp)
	);

	// index bits must not reach into the partial tag
	a_index_w: assert property (@(posedge clk) INDEX_W <= btb_pkg::MAX_INDEX_W);

endmodule

//--- dv/btb_tb_table.svh
//----------------------------------------------------------------------
// operation table for the btb testbench, loaded once before reset ends
//----------------------------------------------------------------------
// columns: name, op, pc, update target, expected hit, expected target
// set index is pc[7:2], partial tag is pc[31:12]
task automatic load_table();
	// empty buffer misses everywhere
	add_row("rst_miss_a", OP_LKP, 32'h0000_1000, 32'h0, 1'b0, 32'h0);
	add_row("rst_miss_b", OP_LKP, 32'hdead_beec, 32'h0, 1'b0, 32'h0);
	add_row("rst_miss_c", OP_LKP, 32'h1000_0014, 32'h0, 1'b0, 32'h0);
	// write then read back, same set other tag misses
	add_row("upd_x", OP_UPD, 32'h0001_0040, 32'h0002_0000, 1'b0, 32'h0);
	add_row("lkp_x", OP_LKP, 32'h0001_0040, 32'h0, 1'b1, 32'h0002_0000);
	add_row("other_tag", OP_LKP, 32'h0003_0040, 32'h0, 1'b0, 32'h0);
	add_row("alias_hit", OP_LKP, 32'h0001_0840, 32'h0, 1'b1, 32'h0002_0000);
	//------------------------------------------------------------------
	// set 5, fill order 0 2 1 3
	//------------------------------------------------------------------
	add_row("fill_a", OP_UPD, 32'h1000_0014, 32'h0000_a000, 1'b0, 32'h0);
	add_row("fill_b", OP_UPD, 32'h2000_0014, 32'h0000_b000, 1'b0, 32'h0);
	add_row("fill_c", OP_UPD, 32'h3000_0014, 32'h0000_c000, 1'b0, 32'h0);
	add_row("fill_d", OP_UPD, 32'h4000_0014, 32'h0000_d000, 1'b0, 32'h0);
	add_row("lkp_a", OP_LKP, 32'h1000_0014, 32'h0, 1'b1, 32'h0000_a000);
	add_row("lkp_b", OP_LKP, 32'h2000_0014, 32'h0, 1'b1, 32'h0000_b000);
	add_row("lkp_c", OP_LKP, 32'h3000_0014, 32'h0, 1'b1, 32'h0000_c000);
	add_row("lkp_d", OP_LKP, 32'h4000_0014, 32'h0, 1'b1, 32'h0000_d000);
	// same tag rewrites way 2, plru then points at way 0
	add_row("rewrite_b", OP_UPD, 32'h2000_0014, 32'h0000_b111, 1'b0, 32'h0);
	add_row("lkp_b2", OP_LKP, 32'h2000_0014, 32'h0, 1'b1, 32'h0000_b111);
	add_row("lkp_a2", OP_LKP, 32'h1000_0014, 32'h0, 1'b1, 32'h0000_a000);
	add_row("lkp_c2", OP_LKP, 32'h3000_0014, 32'h0, 1'b1, 32'h0000_c000);
	add_row("lkp_d2", OP_LKP, 32'h4000_0014, 32'h0, 1'b1, 32'h0000_d000);
	// fifth tag evicts way 0 which holds a
	add_row("evict_e", OP_UPD, 32'h5000_0014, 32'h0000_e000, 1'b0, 32'h0);
	add_row("lkp_e", OP_LKP, 32'h5000_0014, 32'h0, 1'b1, 32'h0000_e000);
	add_row("lkp_a3", OP_LKP, 32'h1000_0014, 32'h0, 1'b0, 32'h0);
	add_row("lkp_b3", OP_LKP, 32'h2000_0014, 32'h0, 1'b1, 32'h0000_b111);
	add_row("lkp_c3", OP_LKP, 32'h3000_0014, 32'h0, 1'b1, 32'h0000_c000);
	add_row("lkp_d3", OP_LKP, 32'h4000_0014, 32'h0, 1'b1, 32'h0000_d000);
	// sixth tag then takes way 3 which holds d
	add_row("evict_f", OP_UPD, 32'h6000_0014, 32'h0000_f000, 1'b0, 32'h0);
	add_row("lkp_d4", OP_LKP, 32'h4000_0014, 32'h0, 1'b0, 32'h0);
	add_row("lkp_f", OP_LKP, 32'h6000_0014, 32'h0, 1'b1, 32'h0000_f000);
	add_row("lkp_b4", OP_LKP, 32'h2000_0014, 32'h0, 1'b1, 32'h0000_b111);
	// lookup right behind an update to the same set, last set
	add_row("upd_y", OP_UPD, 32'h0abc_d0fc, 32'h1234_5678, 1'b0, 32'h0);
	add_row("lkp_y", OP_LKP, 32'h0abc_d0fc, 32'h0, 1'b1, 32'h1234_5678);
	add_row("upd_y2", OP_UPD, 32'h0abc_d0fc, 32'h8765_4320, 1'b0, 32'h0);
	add_row("lkp_y2", OP_LKP, 32'h0abc_d0fc, 32'h0, 1'b1, 32'h8765_4320);
	add_row("lkp_y_ofs", OP_LKP, 32'h0abc_d0ff, 32'h0, 1'b1, 32'h8765_4320);
endtask

//--- dv/btb_tb.sv
//----------------------------------------------------------------------
// testbench for the branch target buffer that applies the operation
// table in order and checks each lookup response under back-pressure
//----------------------------------------------------------------------
module btb_tb;

	localparam int   DRV_DLY = 5;	// input skew after the rising edge
	localparam int   RST_CYC = 10;
	localparam logic OP_UPD  = 1'b1;
	localparam logic OP_LKP  = 1'b0;

	// one table row with expected fields for lookups
	typedef struct packed {
		logic                     upd;
		logic [btb_pkg::PC_W-1:0] pc;
		logic [btb_pkg::PC_W-1:0] target;
		logic                     exp_hit;
		logic [btb_pkg::PC_W-1:0] exp_target;
	} row_t;

	logic              clk;
	logic              arst_n;
	logic              lkp_valid;
	logic              lkp_ready;
	btb_pkg::btb_lkp_t lkp;
	logic              upd_valid;
	logic              upd_ready;
	btb_pkg::btb_upd_t upd;
	logic              rsp_valid;
	logic              rsp_ready;
	btb_pkg::btb_rsp_t rsp;

	row_t              rows [$];
	string             names [$];
	int                exp_q [$];	// rows of lookups awaiting a response
	int                errors;
	int                checks;
	int                cycles;
	int                limit;	// timeout in cycles
	logic [31:0]       lfsr;
	logic              stalled;	// response held over the next edge
	btb_pkg::btb_rsp_t held_rsp;

	btb_top #(
		.INDEX_W (6)	// table rows assume 64 sets
	) dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.lkp_valid (lkp_valid),
		.lkp_ready (lkp_ready),
		.lkp       (lkp),
		.upd_valid (upd_valid),
		.upd_ready (upd_ready),
		.upd       (upd),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

	always #20 clk = ~clk;	// period 40

	// taps x^32 x^22 x^2 x^1 with the new bit shifted in at bit 0
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic add_row(input string name, input logic upd_op,
			input logic [31:0] pc, input logic [31:0] target,
			input logic exp_hit, input logic [31:0] exp_target);
		row_t r;
		r.upd        = upd_op;
		r.pc         = pc;
		r.target     = target;
		r.exp_hit    = exp_hit;
		r.exp_target = exp_target;
		rows.push_back(r);
		names.push_back(name);
	endtask

`include "btb_tb_table.svh"

	//------------------------------------------------------------------
	// driver for one operation at a time on its own stream
	//------------------------------------------------------------------
	task automatic apply_row(input int i);
		row_t r;
		logic fire;
		r = rows[i];
		if (r.upd) begin
			upd_valid  = 1'b1;
			upd.pc     = r.pc;
			upd.target = r.target;
		end else begin
			lkp_valid = 1'b1;
			lkp.pc    = r.pc;
		end
		fire = 1'b0;
		while (!fire) begin
			@(negedge clk);	// ready settled mid-cycle
			fire = (upd_valid && upd_ready) || (lkp_valid && lkp_ready);
			@(posedge clk);	// held until the handshake
		end
		if (!r.upd) begin
			exp_q.push_back(i);	// responses come back in order
		end
		#DRV_DLY;
		upd_valid = 1'b0;
		upd       = '0;
		lkp_valid = 1'b0;
		lkp       = '0;
	endtask

	task automatic check_idle();
		checks++;
		if (rsp_valid !== 1'b0) begin
			errors++;
			$display("FAIL reset_idle rsp_valid exp 0 got %b", rsp_valid);
		end
		if (lkp_ready !== 1'b1) begin
			errors++;
			$display("FAIL reset_idle lkp_ready exp 1 got %b", lkp_ready);
		end
		if (upd_ready !== 1'b1) begin
			errors++;
			$display("FAIL reset_idle upd_ready exp 1 got %b", upd_ready);
		end
	endtask

	task automatic check_rsp();
		int   i;
		row_t r;
		if (exp_q.size() == 0) begin
			errors++;
			$display("response for pc %h arrived with no lookup outstanding", rsp.pc);
		end else begin
			i = exp_q.pop_front();
			r = rows[i];
			checks++;
			if (rsp.hit !== r.exp_hit) begin
				errors++;
				$display("FAIL %s hit exp %0b got %0b", names[i], r.exp_hit, rsp.hit);
			end
			if (rsp.target !== r.exp_target) begin
				errors++;
				$display("FAIL %s target exp %h got %h", names[i], r.exp_target, rsp.target);
			end
			if (rsp.pc !== r.pc) begin
				errors++;
				$display("FAIL %s pc exp %h got %h", names[i], r.pc, rsp.pc);
			end
		end
	endtask

	//------------------------------------------------------------------
	// back-pressure, response checker, timeout
	//------------------------------------------------------------------
	always @(posedge clk) begin
		#DRV_DLY;
		lfsr      = lfsr_step(lfsr);
		rsp_ready = lfsr[0];	// one bit per cycle
	end

	// mid-cycle view of the transfer on the coming edge
	always @(negedge clk) begin
		if (arst_n) begin
			if (stalled && !rsp_valid) begin
				errors++;
				$display("response valid dropped while rsp_ready was low");
			end else if (stalled && (rsp !== held_rsp)) begin
				errors++;
				$display("FAIL stall_hold exp %h got %h", held_rsp, rsp);
			end
			stalled  = rsp_valid && !rsp_ready;
			held_rsp = rsp;
			if (rsp_valid && rsp_ready) begin
				check_rsp();
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d cycles, %0d responses never arrived",
				cycles, exp_q.size());
			$display("checks %0d, errors %0d", checks, errors);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		clk       = 1'b0;
		arst_n    = 1'b0;
		lkp_valid = 1'b0;
		lkp       = '0;
		upd_valid = 1'b0;
		upd       = '0;
		rsp_ready = 1'b0;
		lfsr      = 32'hb6d1;
		errors    = 0;
		checks    = 0;
		cycles    = 0;
		stalled   = 1'b0;
		held_rsp  = '0;
		load_table();
		limit = rows.size() * 8 + 50;
		repeat (RST_CYC) @(posedge clk);
		#DRV_DLY;
		arst_n = 1'b1;
		check_idle();
		for (int i = 0; i < rows.size(); i++) begin
			apply_row(i);
		end
		while (exp_q.size() != 0) begin
			@(posedge clk);	// drain responses
		end
		repeat (4) @(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+dv
src/btb_pkg.sv
src/btb_req_stage.sv
src/btb_way_ram.sv
src/btb_plru.sv
src/btb_tag_match.sv
src/btb_top.sv
dv/btb_tb.sv

//--- run.sh
#!/bin/sh
# build the branch target buffer testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module btb_tb \
	-Mdir obj_dir -o btb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/btb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "simulation exited with an error status, see sim.log"
	exit 1
fi

cat sim.log
if grep -q "Errors found" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation PASSED"
exit 0
